// ==== Bender.yml ====
package:
  name: discrete_audio_stage

sources:
  - discrete_audio_pkg.sv
  - audio_clock_enable.sv
  - resistor_mixer.sv
  - resistor_capacitor_high_pass_filter.sv
  - resistor_capacitor_low_pass_filter.sv
  - discrete_audio_stage.sv
  - target: test
    files:
      - discrete_audio_stage_tb.sv

// ==== audio_clock_enable.sv ====
// Sample-rate enable generator
// Divides the system clock down to a registered strobe that is high for a
// single cycle once every DIV cycles. The first strobe follows DIV cycles
// after reset is released.

`timescale 1ns/1ps
`default_nettype none

module audio_clock_enable
    import discrete_audio_pkg::*;
#(
    parameter int DIV = AUDIO_CLK_DIV
) (
    input  wire  clk,
    input  wire  rst_n,
    output logic audio_clk_en
);

    localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

    logic [CNT_W-1:0] div_cnt;
    logic             wrap;

    assign wrap = (div_cnt == CNT_W'(DIV - 1));  // Last cycle of the sample period

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt      <= '0;
            audio_clk_en <= 1'b0;
        end else begin
            div_cnt      <= wrap ? '0 : div_cnt + 1'b1;
            audio_clk_en <= wrap;  // Strobe lands one cycle after the wrap is seen
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
discrete_audio_pkg.sv
audio_clock_enable.sv
resistor_mixer.sv
resistor_capacitor_high_pass_filter.sv
resistor_capacitor_low_pass_filter.sv
discrete_audio_stage.sv
discrete_audio_stage_tb.sv

// ==== discrete_audio_pkg.sv ====
// Discrete audio stage shared definitions
// Holds the sample type, the sample-rate divider, the component values of
// the mixer and both RC filters, and the fixed-point filter coefficients
// that are derived from them at elaboration time.

`default_nettype none

package discrete_audio_pkg;

    localparam int SAMPLE_W = 16;
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    localparam int AUDIO_CLK_DIV   = 8;      // System clocks per sample in simulation
    localparam int SAMPLE_RATE     = 48000;
    localparam int ALPHA_FRAC_BITS = 16;     // Coefficients are Q16

    // Mixer weights in Q8, standing in for the two input resistors
    localparam int MIX_GAIN_A = 160;
    localparam int MIX_GAIN_B = 96;

    // Capacitances are stored pre-scaled by 2**35 to keep the math integer
    localparam longint HP_R_OHMS       = 47000;
    localparam longint HP_C_35_SHIFTED = 113387;  // 3.3 uF
    localparam longint LP_R_OHMS       = 10000;
    localparam longint LP_C_35_SHIFTED = 3436;    // 0.1 uF

    // Sample period and RC time constants, all scaled by 2**32
    localparam longint DT_32_SHIFTED    = (longint'(1) <<< 32) / SAMPLE_RATE;
    localparam longint HP_RC_32_SHIFTED = (HP_R_OHMS * HP_C_35_SHIFTED) >>> 3;
    localparam longint LP_RC_32_SHIFTED = (LP_R_OHMS * LP_C_35_SHIFTED) >>> 3;

    // High-pass smoothing factor RC / (RC + dt)
    localparam int HP_ALPHA = int'((HP_RC_32_SHIFTED <<< ALPHA_FRAC_BITS) /
                                   (HP_RC_32_SHIFTED + DT_32_SHIFTED));

    // Low-pass smoothing factor dt / (RC + dt)
    localparam int LP_ALPHA = int'((DT_32_SHIFTED <<< ALPHA_FRAC_BITS) /
                                   (LP_RC_32_SHIFTED + DT_32_SHIFTED));

    // Width of the intermediate results that are clamped back to a sample
    localparam int WIDE_W = 40;

    localparam logic signed [WIDE_W-1:0] SAT_HI = (1 <<< (SAMPLE_W - 1)) - 1;
    localparam logic signed [WIDE_W-1:0] SAT_LO = -(1 <<< (SAMPLE_W - 1));

    // Clamps a wide signed value into the sample range
    function automatic sample_t saturate_sample(input logic signed [WIDE_W-1:0] value);
        sample_t result;
        if (value > SAT_HI) begin
            result = sample_t'(SAT_HI);
        end else if (value < SAT_LO) begin
            result = sample_t'(SAT_LO);
        end else begin
            result = sample_t'(value);
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// ==== discrete_audio_stage.sv ====
// Discrete audio analog stage
// Chains the sample-rate enable generator, the resistor mixer, the RC
// high-pass and the RC low-pass filter. Each stage steps on the same
// enable, so a source pair reaches sample_out two enables after capture.

`timescale 1ns/1ps
`default_nettype none

module discrete_audio_stage
    import discrete_audio_pkg::*;
(
    input  wire     clk,
    input  wire     rst_n,
    input  sample_t source_a,
    input  sample_t source_b,
    output logic    audio_clk_en,
    output sample_t sample_out
);

    sample_t mix_sample;
    sample_t hp_sample;

    audio_clock_enable #(
        .DIV          (AUDIO_CLK_DIV)
    ) audio_clock_enable_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .audio_clk_en (audio_clk_en)
    );

    resistor_mixer resistor_mixer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .audio_clk_en (audio_clk_en),
        .source_a     (source_a),
        .source_b     (source_b),
        .mix_sample   (mix_sample)
    );

    resistor_capacitor_high_pass_filter #(
        .ALPHA        (HP_ALPHA)
    ) high_pass_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .audio_clk_en (audio_clk_en),
        .sample_in    (mix_sample),
        .sample_out   (hp_sample)
    );

    resistor_capacitor_low_pass_filter #(
        .ALPHA        (LP_ALPHA)
    ) low_pass_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .audio_clk_en (audio_clk_en),
        .sample_in    (hp_sample),
        .sample_out   (sample_out)
    );

endmodule

`default_nettype wire

// ==== discrete_audio_stage_tb.sv ====
// Discrete audio stage testbench
// Directed tests for reset, the sample-rate enable cadence, a DC step,
// full-scale mixer inputs, a random input program and output hold between
// enables. A three-stage model of the mixer and both RC filters predicts
// every sample_out.

`timescale 1ns/1ps
`default_nettype none

module discrete_audio_stage_tb
    import discrete_audio_pkg::*;
;

    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = 12000;  // About twice the length of all tests
    localparam longint SAMPLE_MAX = (longint'(1) <<< (SAMPLE_W - 1)) - 1;
    localparam longint SAMPLE_MIN = -(longint'(1) <<< (SAMPLE_W - 1));

    logic    clk;
    logic    rst_n;
    sample_t source_a;
    sample_t source_b;
    logic    audio_clk_en;
    sample_t sample_out;

    integer  seed;
    int      error_count;
    int      cycle_count;
    sample_t cur_a;         // Values currently held on the inputs
    sample_t cur_b;

    // Model state, one register per stage
    sample_t model_mix;
    sample_t model_hp;
    sample_t model_hp_in;
    sample_t model_out;

    discrete_audio_stage discrete_audio_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .source_a     (source_a),
        .source_b     (source_b),
        .audio_clk_en (audio_clk_en),
        .sample_out   (sample_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    function automatic sample_t clamp_sample(input longint value);
        if (value > SAMPLE_MAX) begin
            return sample_t'(SAMPLE_MAX);
        end
        if (value < SAMPLE_MIN) begin
            return sample_t'(SAMPLE_MIN);
        end
        return sample_t'(value);
    endfunction

    function automatic sample_t random_sample();
        return sample_t'($random(seed));
    endfunction

    // One enable of the mixer, high-pass and low-pass, all from the old state
    task automatic model_step(input sample_t a, input sample_t b);
        longint mix_wide;
        longint hp_wide;
        longint lp_wide;
        mix_wide = (longint'(a) * MIX_GAIN_A + longint'(b) * MIX_GAIN_B) >>> 8;
        hp_wide  = ((longint'(model_hp) + longint'(model_mix) - longint'(model_hp_in))
                    * HP_ALPHA) >>> ALPHA_FRAC_BITS;
        lp_wide  = longint'(model_out)
                 + (((longint'(model_hp) - longint'(model_out)) * LP_ALPHA) >>> ALPHA_FRAC_BITS);
        model_hp_in = model_mix;
        model_mix   = clamp_sample(mix_wide);
        model_hp    = clamp_sample(hp_wide);
        model_out   = sample_t'(lp_wide);  // Always lies between old output and input
    endtask

    task automatic drive_inputs(input sample_t a, input sample_t b);
        source_a <= a;
        source_b <= b;
        cur_a = a;
        cur_b = b;
    endtask

    task automatic wait_enable();
        @(posedge clk);
        while (audio_clk_en !== 1'b1) begin
            @(posedge clk);
        end
    endtask

    // Drive one input pair, let the enable take it and check the result
    task automatic sample_step(input sample_t a, input sample_t b);
        drive_inputs(a, b);
        wait_enable();
        model_step(cur_a, cur_b);
        @(posedge clk);
        check_sample("sample_out", model_out, sample_out);
    endtask

    // Same as sample_step, but the inputs change on every cycle in between
    task automatic hold_step();
        sample_t held;
        held = sample_out;
        drive_inputs(random_sample(), random_sample());
        @(posedge clk);
        while (audio_clk_en !== 1'b1) begin
            check_sample("sample_out", held, sample_out);
            drive_inputs(random_sample(), random_sample());
            @(posedge clk);
        end
        check_sample("sample_out", held, sample_out);
        model_step(cur_a, cur_b);  // Only the pair held at the enable edge counts
        @(posedge clk);
        check_sample("sample_out", model_out, sample_out);
    endtask

    task automatic reset_sequence();
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            check_bit("audio_clk_en", 1'b0, audio_clk_en);
            check_sample("sample_out", '0, sample_out);
        end
        rst_n <= 1'b1;
    endtask

    task automatic enable_cadence();
        for (int i = 0; i < AUDIO_CLK_DIV; i++) begin
            @(posedge clk);
            check_bit("audio_clk_en", 1'b0, audio_clk_en);
            check_sample("sample_out", '0, sample_out);
        end
        @(posedge clk);
        check_bit("audio_clk_en", 1'b1, audio_clk_en);
        model_step(cur_a, cur_b);
        repeat (19) begin
            repeat (AUDIO_CLK_DIV - 1) begin
                @(posedge clk);
                check_bit("audio_clk_en", 1'b0, audio_clk_en);
            end
            @(posedge clk);
            check_bit("audio_clk_en", 1'b1, audio_clk_en);
            model_step(cur_a, cur_b);
        end
        @(posedge clk);
        check_bit("audio_clk_en", 1'b0, audio_clk_en);  // Last pulse is one cycle wide
    endtask

    task automatic dc_step();
        sample_t dc_a;
        sample_t dc_b;
        longint  mix_level;
        longint  dc_pass_level;
        dc_a          = 16'sd12000;
        dc_b          = 16'sd8000;
        mix_level     = (longint'(dc_a) * MIX_GAIN_A + longint'(dc_b) * MIX_GAIN_B) >>> 8;
        dc_pass_level = 0;
        for (int i = 0; i < 200; i++) begin
            sample_step(dc_a, dc_b);
            if (i >= 2) begin  // The low-pass sees the mix from the third enable on
                dc_pass_level = dc_pass_level
                              + (((mix_level - dc_pass_level) * LP_ALPHA) >>> ALPHA_FRAC_BITS);
            end
        end
        // A stage that kept the DC would have reached dc_pass_level by now
        if (sample_out <= 0 || longint'(sample_out) >= dc_pass_level) begin
            error_count++;
            $display("ERROR at %0t: sample_out %0d is not between zero and the DC level %0d",
                     $time, sample_out, dc_pass_level);
        end
    endtask

    task automatic mixer_saturation();
        repeat (40) begin
            sample_step(sample_t'(SAMPLE_MAX), sample_t'(SAMPLE_MAX));
        end
        repeat (40) begin
            sample_step(sample_t'(SAMPLE_MIN), sample_t'(SAMPLE_MIN));  // Swing can clamp the HP
        end
        repeat (20) begin
            sample_step('0, '0);
        end
    endtask

    task automatic random_program();
        repeat (300) begin
            sample_step(random_sample(), random_sample());
        end
    endtask

    task automatic hold_between_enables();
        repeat (30) begin
            hold_step();
        end
    endtask

    initial begin
        seed        = 32'hd92b787a;
        error_count = 0;
        rst_n       = 1'b0;
        source_a    = '0;
        source_b    = '0;
        cur_a       = '0;
        cur_b       = '0;
        model_mix   = '0;
        model_hp    = '0;
        model_hp_in = '0;
        model_out   = '0;

        reset_sequence();
        enable_cadence();
        dc_step();
        mixer_saturation();
        random_program();
        hold_between_enables();

        $display("Checks finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== resistor_capacitor_high_pass_filter.sv ====
// First-order RC high-pass filter
// Runs the discrete recursion y[n] = a * (y[n-1] + x[n] - x[n-1]) once per
// sample-rate enable, with a in Q16. Removes the DC component from the
// mix while passing the audio band nearly untouched.

`timescale 1ns/1ps
`default_nettype none

module resistor_capacitor_high_pass_filter
    import discrete_audio_pkg::*;
#(
    parameter int ALPHA = HP_ALPHA
) (
    input  wire     clk,
    input  wire     rst_n,
    input  wire     audio_clk_en,
    input  sample_t sample_in,
    output sample_t sample_out
);

    localparam int COEF_W = ALPHA_FRAC_BITS + 2;  // Unsigned Q16 plus a sign bit
    localparam int DIFF_W = SAMPLE_W + 2;
    localparam int PROD_W = DIFF_W + COEF_W;

    localparam logic signed [COEF_W-1:0] ALPHA_S = COEF_W'(ALPHA);

    sample_t                  prev_in;
    logic signed [DIFF_W-1:0] delta;
    logic signed [PROD_W-1:0] product;
    logic signed [PROD_W-1:0] next_wide;

    always_comb begin
        // Previous output plus the change of the input since the last step
        delta     = sample_out + sample_in - prev_in;
        product   = delta * ALPHA_S;
        next_wide = product >>> ALPHA_FRAC_BITS;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_in    <= '0;
            sample_out <= '0;
        end else if (audio_clk_en) begin
            prev_in    <= sample_in;
            sample_out <= saturate_sample(next_wide);  // A full-scale step can overshoot
        end
    end

endmodule

`default_nettype wire

// ==== resistor_capacitor_low_pass_filter.sv ====
// First-order RC low-pass filter
// Each sample-rate enable moves the output a fraction a of the way toward
// the input, y[n] = y[n-1] + a * (x[n] - y[n-1]), with a in Q16.
// The step is always a fraction of the gap, so the output stays in range.

`timescale 1ns/1ps
`default_nettype none

module resistor_capacitor_low_pass_filter
    import discrete_audio_pkg::*;
#(
    parameter int ALPHA = LP_ALPHA
) (
    input  wire     clk,
    input  wire     rst_n,
    input  wire     audio_clk_en,
    input  sample_t sample_in,
    output sample_t sample_out
);

    localparam int COEF_W = ALPHA_FRAC_BITS + 2;
    localparam int DIFF_W = SAMPLE_W + 1;
    localparam int PROD_W = DIFF_W + COEF_W;

    localparam logic signed [COEF_W-1:0] ALPHA_S = COEF_W'(ALPHA);

    logic signed [DIFF_W-1:0] gap;
    logic signed [PROD_W-1:0] product;
    logic signed [DIFF_W-1:0] step;
    logic signed [DIFF_W-1:0] next_wide;

    always_comb begin
        gap       = sample_in - sample_out;
        product   = gap * ALPHA_S;
        step      = DIFF_W'(product >>> ALPHA_FRAC_BITS);  // Never larger than the gap
        next_wide = sample_out + step;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_out <= '0;
        end else if (audio_clk_en) begin
            sample_out <= sample_t'(next_wide);  // Lies between old output and input
        end
    end

endmodule

`default_nettype wire

// ==== resistor_mixer.sv ====
// Resistor network mixer
// Sums two signed sources with fixed Q8 weights, the way two summing
// resistors into a common node would. The sum is clamped to the sample
// range and captured on each sample-rate enable.

`timescale 1ns/1ps
`default_nettype none

module resistor_mixer
    import discrete_audio_pkg::*;
(
    input  wire     clk,
    input  wire     rst_n,
    input  wire     audio_clk_en,
    input  sample_t source_a,
    input  sample_t source_b,
    output sample_t mix_sample
);

    localparam int GAIN_W = 10;  // Room for the Q8 gains as signed values
    localparam int PROD_W = SAMPLE_W + GAIN_W;
    localparam int SUM_W  = PROD_W + 1;

    localparam logic signed [GAIN_W-1:0] GAIN_A = GAIN_W'(MIX_GAIN_A);
    localparam logic signed [GAIN_W-1:0] GAIN_B = GAIN_W'(MIX_GAIN_B);

    logic signed [PROD_W-1:0] weighted_a;
    logic signed [PROD_W-1:0] weighted_b;
    logic signed [SUM_W-1:0]  weighted_sum;
    logic signed [SUM_W-1:0]  scaled_sum;

    always_comb begin
        weighted_a   = source_a * GAIN_A;
        weighted_b   = source_b * GAIN_B;
        weighted_sum = weighted_a + weighted_b;
        scaled_sum   = weighted_sum >>> 8;  // Drop the Q8 fraction
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mix_sample <= '0;
        end else if (audio_clk_en) begin
            mix_sample <= saturate_sample(scaled_sum);
        end
    end

endmodule

`default_nettype wire
